//--- csr_stage_cases.txt
# name cmd addr op mtime mtimecmp irq_ready fetch_pc hazard sel expected (all but cmd/flags/sel hex)
# cmd 0 none 1 w 2 s 3 c 4 ecall 5 mret; sel 0 rdata 1 tvec 2 stall 3 cmd_out 4 cycle lo 5 cycle hi
w_mscratch 1 340 a5a50000 0 1000 0 0 0 0 00000000
s_mscratch 2 340 000000ff 0 1000 0 0 0 0 a5a50000
c_mscratch 3 340 a5000000 0 1000 0 0 0 0 a5a500ff
rd_mscratch 0 340 0 0 1000 0 0 0 0 00a500ff
w_mtvec 1 305 00001000 0 1000 0 0 0 0 00000000
s_mtvec 2 305 00000040 0 1000 0 0 0 0 00001000
rd_mtvec 0 305 0 0 1000 0 0 0 0 00001040
w_mstatus 1 300 ffffffff 0 1000 0 0 0 0 00001800
rd_mstatus 0 300 0 0 1000 0 0 0 0 00001888
ecall_m_cmd 4 0 0 0 1000 0 0 0 3 00000004
ecall_m_tvec 0 0 0 0 1000 0 0 0 1 00001040
rd_mcause_m 0 342 0 0 1000 0 0 0 0 0000000b
w_mepc 1 341 00002000 0 1000 0 0 0 0 00000000
c_mstatus_mpp 3 300 00001800 0 1000 0 0 0 0 00001880
mret_tvec 5 0 0 0 1000 0 0 0 1 00002000
ecall_u_cmd 4 0 0 0 1000 0 0 0 3 00000004
rd_mcause_u 0 342 0 0 1000 0 0 0 0 00000008
mret_to_u 5 0 0 0 1000 0 0 0 1 00002000
rd_cycle_denied 0 c00 0 0 1000 0 0 0 0 00000000
rd_cycleh_denied 0 c80 0 0 1000 0 0 0 0 00000000
ecall_back 4 0 0 0 1000 0 0 0 3 00000004
s_mcounteren 2 306 00000001 0 1000 0 0 0 0 00000000
mret_to_u2 5 0 0 0 1000 0 0 0 1 00002000
rd_cycle_user 0 c00 0 0 1000 0 0 0 4 00000000
rd_cycleh_user 0 c80 0 0 1000 0 0 0 5 00000000
rd_time_denied 0 c01 0 0 1000 0 0 0 0 00000000
ecall_to_m 4 0 0 0 1000 0 0 0 3 00000004
w_mie 1 304 ffffffff 0 1000 0 0 0 0 00000000
rd_mie 0 304 0 0 1000 0 0 0 0 00000888
s_mstatus_mie 2 300 00000008 0 1000 0 0 0 0 00000080
stall_low 0 0 0 0 1000 0 0 0 2 00000000
stall_high 0 0 0 1000 1000 0 0 0 2 00000001
irq_take_cmd 0 0 0 1000 1000 1 00003004 0 3 00000004
irq_tvec 0 0 0 0 1000 0 0 0 1 00001040
rd_mepc_irq 0 341 0 0 1000 0 0 0 0 00003004
rd_mcause_irq 0 342 0 0 1000 0 0 0 0 80000007
rd_mstatus_irq 0 300 0 0 1000 0 0 0 0 00001880
hazard_w 1 340 deadbeef 0 1000 0 0 1 3 00000000
rd_mscratch_kept 0 340 0 0 1000 0 0 0 0 00a500ff

//--- csr_stage.f
+incdir+.
csr_types_pkg.sv
priv_pkg.sv
csr_write_stage.sv
csr_trap_ctrl.sv
csr_regs.sv
csr_read_mux.sv
csr_stage.sv
tb_csr_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the CSR stage testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_csr_stage \
    -f csr_stage.f -o sim_csr_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_csr_stage > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- tb_csr_stage.sv
`default_nettype none

`include "csr_defs.svh"

module tb_csr_stage
    import csr_types_pkg::*;
();

    logic       clk;
    logic       arst_n;
    counter_t   cycle_count;
    counter_t   time_count;
    counter_t   mtime;
    counter_t   mtimecmp;
    logic       branch_hazard;
    csr_cmd_e   csr_cmd_in;
    csr_data_t  op1_data;
    csr_data_t  imm_i;
    logic       interrupt_ready;
    csr_data_t  fetch_pc;
    csr_cmd_e   csr_cmd_out;
    csr_data_t  csr_rdata;
    csr_data_t  trap_vector;
    logic       stall_may_interrupt;

    // One entry per case line
    string      case_name[$];
    logic [2:0] case_cmd[$];
    csr_data_t  case_addr[$];
    csr_data_t  case_op[$];
    counter_t   case_mtime[$];
    counter_t   case_mtimecmp[$];
    logic       case_irq_rdy[$];
    csr_data_t  case_pc[$];
    logic       case_hazard[$];
    int         case_sel[$];
    csr_data_t  case_exp[$];

    integer     seed;
    int         cycles;
    int         cycle_limit;

    csr_stage i_csr_stage (
        .clk                 (clk),
        .arst_n              (arst_n),
        .cycle_count         (cycle_count),
        .time_count          (time_count),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .branch_hazard       (branch_hazard),
        .csr_cmd_in          (csr_cmd_in),
        .op1_data            (op1_data),
        .imm_i               (imm_i),
        .interrupt_ready     (interrupt_ready),
        .fetch_pc            (fetch_pc),
        .csr_cmd_out         (csr_cmd_out),
        .csr_rdata           (csr_rdata),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    always #10 clk = ~clk;

    // Free-running counters seen by the cycle and time CSRs
    always @(negedge clk) begin
        cycle_count = cycle_count + 64'd1;
        time_count  = time_count + 64'd1;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input csr_data_t expected,
                               input csr_data_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch in case %s", name);
        end
    endtask

    task automatic drive_idle();
        csr_cmd_in      = CSR_NONE;
        branch_hazard   = 1'b0;
        interrupt_ready = 1'b0;
    endtask

    // Entered and left at a falling edge
    task automatic run_case(input int i);
        counter_t  edge_count;
        csr_data_t actual;
        csr_data_t expected;
        csr_cmd_in      = csr_cmd_e'(case_cmd[i]);
        imm_i           = case_addr[i];
        op1_data        = case_op[i];
        mtime           = case_mtime[i];
        mtimecmp        = case_mtimecmp[i];
        interrupt_ready = case_irq_rdy[i];
        fetch_pc        = case_pc[i];
        branch_hazard   = case_hazard[i];
        @(posedge clk);
        edge_count = cycle_count;
        @(negedge clk);
        expected = case_exp[i];
        actual   = '0;
        case (case_sel[i])
            0: actual = csr_rdata;
            1: actual = trap_vector;
            2: actual = {31'b0, stall_may_interrupt};
            3: actual = csr_data_t'(csr_cmd_out);
            4: begin
                actual   = csr_rdata;
                expected = edge_count[31:0];
            end
            5: begin
                actual   = csr_rdata;
                expected = edge_count[63:32];
            end
            default: begin
                $display("Case %s has an unknown check selector", case_name[i]);
                $display("RESULT: FAIL");
                $fatal(1, "Bad case file");
            end
        endcase
        check_value(case_name[i], expected, actual);
        // Let the write land before the next command reads it
        if (case_cmd[i] inside {3'd1, 3'd2, 3'd3}) begin
            drive_idle();
            @(negedge clk);
        end
    endtask

    initial begin
        int         fd;
        int         n;
        int         cmd_val;
        int         rdy_val;
        int         haz_val;
        int         sel_val;
        string      line;
        string      name;
        csr_data_t  addr_val;
        csr_data_t  op_val;
        counter_t   mt_val;
        counter_t   cmp_val;
        csr_data_t  pc_val;
        csr_data_t  exp_val;
        clk             = 1'b0;
        arst_n          = 1'b0;
        cycles          = 0;
        cycle_limit     = 50;
        seed            = 64;
        cycle_count[63:32] = $random(seed);
        cycle_count[31:0]  = $random(seed);
        time_count      = '0;
        mtime           = '0;
        mtimecmp        = '0;
        op1_data        = '0;
        imm_i           = '0;
        fetch_pc        = '0;
        drive_idle();

        fd = $fopen("csr_stage_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file csr_stage_cases.txt");
            $display("RESULT: FAIL");
            $fatal(1, "No stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %d %h %h %h %h %d %h %d %d %h", name, cmd_val,
                            addr_val, op_val, mt_val, cmp_val, rdy_val, pc_val,
                            haz_val, sel_val, exp_val);
                if (n != 11) begin
                    $display("Malformed line in the case file: %s", line);
                    $display("RESULT: FAIL");
                    $fatal(1, "Bad case file");
                end
                case_name.push_back(name);
                case_cmd.push_back(cmd_val[2:0]);
                case_addr.push_back(addr_val);
                case_op.push_back(op_val);
                case_mtime.push_back(mt_val);
                case_mtimecmp.push_back(cmp_val);
                case_irq_rdy.push_back(rdy_val[0]);
                case_pc.push_back(pc_val);
                case_hazard.push_back(haz_val[0]);
                case_sel.push_back(sel_val);
                case_exp.push_back(exp_val);
            end
        end
        $fclose(fd);
        // Each case takes at most two cycles
        cycle_limit = 4 * case_name.size() + 50;

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < case_name.size(); i++) begin
            run_case(i);
        end
        drive_idle();

        if (case_name.size() == 0) begin
            $display("The case file holds no cases");
            $display("RESULT: FAIL");
            $fatal(1, "No stimulus");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- csr_stage.sv
`default_nettype none

`include "csr_defs.svh"

module csr_stage
    import csr_types_pkg::*;
    import priv_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,
    input  wire counter_t   cycle_count,
    input  wire counter_t   time_count,
    input  wire counter_t   mtime,
    input  wire counter_t   mtimecmp,
    input  wire             branch_hazard,
    input  wire csr_cmd_e   csr_cmd_in,
    input  wire csr_data_t  op1_data,
    input  wire csr_data_t  imm_i,
    input  wire             interrupt_ready,
    input  wire csr_data_t  fetch_pc,
    output csr_cmd_e        csr_cmd_out,
    output csr_data_t       csr_rdata,
    output csr_data_t       trap_vector,
    output logic            stall_may_interrupt
);

    csr_cmd_e   cmd_eff;
    csr_cmd_e   cmd_wr;
    csr_addr_t  csr_addr;
    logic       irq_take;
    logic       wr_en;
    csr_addr_t  wr_addr;
    csr_data_t  wr_data;
    priv_mode_e mode;
    csr_data_t  mstatus_word;
    csr_data_t  mepc;
    mcause_t    mcause;
    logic       mtip;
    csr_data_t  mtvec;
    csr_data_t  mscratch;
    csr_data_t  mie_word;
    csr_data_t  mip_sw_bits;
    logic       mcounteren_cy;
    logic       mcounteren_tm;

    // Squash on a taken branch further down the pipe
    assign cmd_eff  = branch_hazard ? CSR_NONE : csr_cmd_in;
    assign csr_addr = imm_i[`CSR_ADDR_W-1:0];

    // A command displaced by the timer trap must not write
    assign cmd_wr = irq_take ? CSR_NONE : cmd_eff;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_cmd_out <= CSR_NONE;
        end else begin
            csr_cmd_out <= irq_take ? CSR_ECALL : cmd_eff;
        end
    end

    csr_write_stage i_write_stage (
        .clk     (clk),
        .arst_n  (arst_n),
        .cmd     (cmd_wr),
        .addr    (csr_addr),
        .op1     (op1_data),
        .rdata   (csr_rdata),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

    csr_trap_ctrl i_trap_ctrl (
        .clk                 (clk),
        .arst_n              (arst_n),
        .cmd                 (cmd_eff),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .interrupt_ready     (interrupt_ready),
        .fetch_pc            (fetch_pc),
        .mtvec               (mtvec),
        .mie_mtie            (mie_word[`IRQ_MTI_BIT]),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .mode                (mode),
        .mstatus_word        (mstatus_word),
        .mepc                (mepc),
        .mcause              (mcause),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt),
        .irq_take            (irq_take),
        .mtip                (mtip)
    );

    csr_regs i_regs (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .mtvec         (mtvec),
        .mscratch      (mscratch),
        .mie_word      (mie_word),
        .mip_sw_bits   (mip_sw_bits),
        .mcounteren_cy (mcounteren_cy),
        .mcounteren_tm (mcounteren_tm)
    );

    csr_read_mux i_read_mux (
        .clk           (clk),
        .arst_n        (arst_n),
        .addr          (csr_addr),
        .mode          (mode),
        .cycle_count   (cycle_count),
        .time_count    (time_count),
        .mtip          (mtip),
        .mstatus_word  (mstatus_word),
        .mepc          (mepc),
        .mcause        (mcause),
        .mtvec         (mtvec),
        .mscratch      (mscratch),
        .mie_word      (mie_word),
        .mip_sw_bits   (mip_sw_bits),
        .mcounteren_cy (mcounteren_cy),
        .mcounteren_tm (mcounteren_tm),
        .csr_rdata     (csr_rdata)
    );

endmodule

`default_nettype wire

//--- csr_read_mux.sv
`default_nettype none

`include "csr_defs.svh"

module csr_read_mux
    import csr_types_pkg::*;
    import priv_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    input  wire csr_addr_t   addr,
    input  wire priv_mode_e  mode,
    input  wire counter_t    cycle_count,
    input  wire counter_t    time_count,
    input  wire              mtip,
    input  wire csr_data_t   mstatus_word,
    input  wire csr_data_t   mepc,
    input  wire mcause_t     mcause,
    input  wire csr_data_t   mtvec,
    input  wire csr_data_t   mscratch,
    input  wire csr_data_t   mie_word,
    input  wire csr_data_t   mip_sw_bits,
    input  wire              mcounteren_cy,
    input  wire              mcounteren_tm,
    output csr_data_t        csr_rdata
);

    logic      cy_ok;
    logic      tm_ok;
    csr_data_t mip_word;
    csr_data_t mcounteren_word;
    csr_data_t rd_next;

    // User mode needs the matching mcounteren bit
    assign cy_ok = (mode == PRIV_M) || mcounteren_cy;
    assign tm_ok = (mode == PRIV_M) || mcounteren_tm;

    always_comb begin
        mip_word = mip_sw_bits;
        mip_word[`IRQ_MTI_BIT] = mtip;
        mcounteren_word = '0;
        mcounteren_word[`MCOUNTEREN_CY] = mcounteren_cy;
        mcounteren_word[`MCOUNTEREN_TM] = mcounteren_tm;
    end

    always_comb begin
        case (addr)
            `CSR_ADDR_CYCLE:      rd_next = cy_ok ? cycle_count[`CSR_XLEN-1:0] : '0;
            `CSR_ADDR_CYCLEH:     rd_next = cy_ok ? cycle_count[2*`CSR_XLEN-1:`CSR_XLEN] : '0;
            `CSR_ADDR_TIME:       rd_next = tm_ok ? time_count[`CSR_XLEN-1:0] : '0;
            `CSR_ADDR_TIMEH:      rd_next = tm_ok ? time_count[2*`CSR_XLEN-1:`CSR_XLEN] : '0;
            `CSR_ADDR_MSTATUS:    rd_next = mstatus_word;
            `CSR_ADDR_MIE:        rd_next = mie_word;
            `CSR_ADDR_MTVEC:      rd_next = mtvec;
            `CSR_ADDR_MCOUNTEREN: rd_next = mcounteren_word;
            `CSR_ADDR_MSCRATCH:   rd_next = mscratch;
            `CSR_ADDR_MEPC:       rd_next = mepc;
            `CSR_ADDR_MCAUSE:     rd_next = mcause;
            `CSR_ADDR_MIP:        rd_next = mip_word;
            default:              rd_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_rdata <= '0;
        end else begin
            csr_rdata <= rd_next;
        end
    end

endmodule

`default_nettype wire

//--- csr_regs.sv
`default_nettype none

`include "csr_defs.svh"

module csr_regs
    import csr_types_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,
    input  wire             wr_en,
    input  wire csr_addr_t  wr_addr,
    input  wire csr_data_t  wr_data,
    output csr_data_t       mtvec,
    output csr_data_t       mscratch,
    output csr_data_t       mie_word,
    output csr_data_t       mip_sw_bits,
    output logic            mcounteren_cy,
    output logic            mcounteren_tm
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec         <= '0;
            mscratch      <= '0;
            mie_word      <= '0;
            mip_sw_bits   <= '0;
            mcounteren_cy <= 1'b0;
            mcounteren_tm <= 1'b0;
        end else if (wr_en) begin
            case (wr_addr)
                `CSR_ADDR_MTVEC:    mtvec    <= wr_data;
                `CSR_ADDR_MSCRATCH: mscratch <= wr_data;
                // Machine enables only
                `CSR_ADDR_MIE:      mie_word <= wr_data & `CSR_MIE_WMASK;
                // User pending bits; MTIP is not stored here
                `CSR_ADDR_MIP:      mip_sw_bits <= wr_data & `CSR_MIP_SW_MASK;
                `CSR_ADDR_MCOUNTEREN: begin
                    mcounteren_cy <= wr_data[`MCOUNTEREN_CY];
                    mcounteren_tm <= wr_data[`MCOUNTEREN_TM];
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- csr_trap_ctrl.sv
`default_nettype none

`include "csr_defs.svh"

module csr_trap_ctrl
    import csr_types_pkg::*;
    import priv_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,
    input  wire csr_cmd_e   cmd,
    input  wire counter_t   mtime,
    input  wire counter_t   mtimecmp,
    input  wire             interrupt_ready,
    input  wire csr_data_t  fetch_pc,
    input  wire csr_data_t  mtvec,
    input  wire             mie_mtie,
    input  wire             wr_en,
    input  wire csr_addr_t  wr_addr,
    input  wire csr_data_t  wr_data,
    output priv_mode_e      mode,
    output csr_data_t       mstatus_word,
    output csr_data_t       mepc,
    output mcause_t         mcause,
    output csr_data_t       trap_vector,
    output logic            stall_may_interrupt,
    output logic            irq_take,
    output logic            mtip
);

    logic       st_mie;
    logic       st_mpie;
    priv_mode_e st_mpp;
    logic       wr_mstatus;
    logic       wr_mepc;
    logic       wr_mcause;
    logic       trap_in;

    assign wr_mstatus = wr_en && (wr_addr == `CSR_ADDR_MSTATUS);
    assign wr_mepc    = wr_en && (wr_addr == `CSR_ADDR_MEPC);
    assign wr_mcause  = wr_en && (wr_addr == `CSR_ADDR_MCAUSE);

    assign mtip = (mtime >= mtimecmp);

    // Lower mode ignores the global enable
    assign stall_may_interrupt = mtip && mie_mtie && ((mode == PRIV_U) || st_mie);
    assign irq_take = stall_may_interrupt && interrupt_ready;

    // Either trap source stacks the interrupt state
    assign trap_in = irq_take || (cmd == CSR_ECALL);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= PRIV_M;
            trap_vector <= '0;
        end else if (trap_in) begin
            mode        <= PRIV_M;
            trap_vector <= mtvec;
        end else if (cmd == CSR_MRET) begin
            mode        <= st_mpp;
            trap_vector <= mepc;
        end
    end

    // CSR write is assigned last so it wins over a trap on the same edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_mie  <= 1'b0;
            st_mpie <= 1'b0;
            st_mpp  <= PRIV_M;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            if (trap_in) begin
                st_mpp  <= mode;
                st_mpie <= st_mie;
                st_mie  <= 1'b0;
            end else if (cmd == CSR_MRET) begin
                st_mpp  <= PRIV_U;
                st_mie  <= st_mpie;
            end
            if (irq_take) begin
                mepc   <= fetch_pc;
                mcause <= `MCAUSE_MTI;
            end else if (cmd == CSR_ECALL) begin
                mcause <= `MCAUSE_ECALL_BASE + mcause_t'(mode);
            end
            if (wr_mstatus) begin
                st_mie  <= wr_data[`MSTATUS_MIE];
                st_mpie <= wr_data[`MSTATUS_MPIE];
                // Only U and M exist so a nonzero field maps to M
                st_mpp  <= (wr_data[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] == 2'b00) ? PRIV_U : PRIV_M;
            end
            if (wr_mepc) begin
                mepc <= wr_data;
            end
            if (wr_mcause) begin
                mcause <= wr_data;
            end
        end
    end

    always_comb begin
        mstatus_word = '0;
        mstatus_word[`MSTATUS_MIE] = st_mie;
        mstatus_word[`MSTATUS_MPIE] = st_mpie;
        mstatus_word[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = st_mpp;
    end

    a_mode_legal: assert property (@(posedge clk) disable iff (!arst_n)
        mode inside {PRIV_U, PRIV_M});

    // A taken interrupt masks itself until software sets MIE again
    a_irq_masks_self: assert property (@(posedge clk) disable iff (!arst_n)
        irq_take && !wr_mstatus |=> !stall_may_interrupt);

endmodule

`default_nettype wire

//--- csr_write_stage.sv
`default_nettype none

`include "csr_defs.svh"

module csr_write_stage
    import csr_types_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,
    input  wire csr_cmd_e   cmd,
    input  wire csr_addr_t  addr,
    input  wire csr_data_t  op1,
    input  wire csr_data_t  rdata,
    output logic            wr_en,
    output csr_addr_t       wr_addr,
    output csr_data_t       wr_data
);

    csr_cmd_e  save_cmd;
    csr_addr_t save_addr;
    csr_data_t save_op1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            save_cmd <= CSR_NONE;
        end else begin
            save_cmd <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        save_addr <= addr;
        save_op1  <= op1;
    end

    assign wr_en   = (save_cmd == CSR_W) || (save_cmd == CSR_S) || (save_cmd == CSR_C);
    assign wr_addr = save_addr;

    // rdata is the old value, registered by the read mux one edge ago
    always_comb begin
        case (save_cmd)
            CSR_S:   wr_data = rdata | save_op1;
            CSR_C:   wr_data = rdata & ~save_op1;
            default: wr_data = save_op1;
        endcase
    end

    // A set or clear right behind a write to the same CSR would use stale rdata
    a_rmw_spacing: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> !((cmd inside {CSR_S, CSR_C}) && (addr == wr_addr)));

endmodule

`default_nettype wire

//--- priv_pkg.sv
`default_nettype none

`include "csr_defs.svh"

package priv_pkg;

    // Encodings follow the privileged spec
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_mode_e;

    // Top bit flags an interrupt
    typedef logic [`CSR_XLEN-1:0] mcause_t;

endpackage

`default_nettype wire

//--- csr_types_pkg.sv
`default_nettype none

`include "csr_defs.svh"

package csr_types_pkg;

    typedef logic [`CSR_XLEN-1:0] csr_data_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // Low word in the bottom half
    typedef logic [2*`CSR_XLEN-1:0] counter_t;

    typedef enum logic [`CSR_CMD_W-1:0] {
        CSR_NONE  = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

endpackage

`default_nettype wire

//--- csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Architectural widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_CMD_W           3

// Machine CSR addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MCOUNTEREN 12'h306
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344

// Read-only user counters
`define CSR_ADDR_CYCLE      12'hc00
`define CSR_ADDR_TIME       12'hc01
`define CSR_ADDR_CYCLEH     12'hc80
`define CSR_ADDR_TIMEH      12'hc81

// Trap causes
`define MCAUSE_ECALL_BASE   32'd8
`define MCAUSE_MTI          32'h8000_0007

// mstatus fields
`define MSTATUS_MIE         3
`define MSTATUS_MPIE        7
`define MSTATUS_MPP_LO      11
`define MSTATUS_MPP_HI      12

// Interrupt enable/pending bits and writable masks
`define IRQ_MTI_BIT         7
`define CSR_MIE_WMASK       32'h0000_0888
`define CSR_MIP_SW_MASK     32'h0000_0111
`define MCOUNTEREN_CY       0
`define MCOUNTEREN_TM       1

`endif
